// ==== hw/matmul_pkg.sv ====
// Matmul package with the tile geometry, fixed-point widths and run configuration types
`default_nettype none

package matmul_pkg;

  // Compute tile geometry
  localparam int TILE_DIM   = 2;
  localparam int TILE_ELEMS = TILE_DIM * TILE_DIM;

  // Largest tile count along any matrix dimension
  localparam int MAX_DEPTH  = 2;

  // B store holds one full inner x b_cols set
  localparam int BUF_DEPTH  = MAX_DEPTH * MAX_DEPTH;
  localparam int BUF_IDX_W  = $clog2(BUF_DEPTH);

  // Accumulator select width
  localparam int ACC_PTR_W  = $clog2(MAX_DEPTH);

  // Inputs carry 1 fractional bit
  typedef logic signed [7:0]  a_elem_t;
  typedef logic signed [7:0]  b_elem_t;
  // Product and sums carry 2 fractional bits
  typedef logic signed [16:0] prod_elem_t;
  typedef logic signed [17:0] acc_elem_t;
  typedef logic signed [15:0] out_elem_t;

  // Tile count, legal values 1 and 2
  typedef logic [1:0] depth_t;

  // Tiles are row-major with element 0 in the top bits
  typedef struct packed {
    a_elem_t [0:TILE_ELEMS-1] e;
  } a_tile_t;

  typedef struct packed {
    b_elem_t [0:TILE_ELEMS-1] e;
  } b_tile_t;

  typedef struct packed {
    prod_elem_t [0:TILE_ELEMS-1] e;
  } prod_tile_t;

  typedef struct packed {
    acc_elem_t [0:TILE_ELEMS-1] e;
  } acc_tile_t;

  typedef struct packed {
    out_elem_t [0:TILE_ELEMS-1] e;
  } out_tile_t;

  // Per-run tile depths
  typedef struct packed {
    depth_t a_rows;
    depth_t inner;
    depth_t b_cols;
  } depth_cfg_t;

  typedef enum logic {
    FILL,
    REPLAY
  } buf_state_t;

  typedef enum logic {
    SUM,
    HOLD
  } acc_state_t;

endpackage

`default_nettype wire

// ==== hw/a_tile_repeater.sv ====
// A tile repeater that holds one tile and presents it repeat_n times downstream
`timescale 1ns/1ps
`default_nettype none

module a_tile_repeater (
  input  wire                      clk,
  input  wire                      rst,
  input  wire matmul_pkg::depth_t  repeat_n,
  input  wire matmul_pkg::a_tile_t in_tile,
  input  wire                      in_valid,
  output logic                     in_ready,
  output matmul_pkg::a_tile_t      out_tile,
  output logic                     out_valid,
  input  wire                      out_ready
);

  // Slot occupancy
  logic               full_q;
  // Transfers already made from the held tile
  matmul_pkg::depth_t cnt_q;
  logic               out_fire;
  logic               last_xfer;

  assign out_valid = full_q;
  assign out_fire  = full_q && out_ready;

  // Final presentation of the held tile
  assign last_xfer = out_fire && (matmul_pkg::depth_t'(cnt_q + 2'd1) == repeat_n);

  // Slot empty, or it empties on this edge
  assign in_ready  = !full_q || last_xfer;

  always_ff @(posedge clk) begin
    if (rst) begin
      full_q <= 1'b0;
      cnt_q  <= '0;
    end else if (in_valid && in_ready) begin
      // New tile replaces the old one in the same cycle
      full_q <= 1'b1;
      cnt_q  <= '0;
    end else if (last_xfer) begin
      full_q <= 1'b0;
      cnt_q  <= '0;
    end else if (out_fire) begin
      cnt_q <= cnt_q + 2'd1;
    end
  end

  // Tile payload
  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_tile <= in_tile;
    end
  end

endmodule

`default_nettype wire

// ==== hw/b_tile_buffer.sv ====
// B tile buffer that forwards and stores the B set, then replays it for extra A tile rows
`timescale 1ns/1ps
`default_nettype none

module b_tile_buffer (
  input  wire                         clk,
  input  wire                         rst,
  input  wire matmul_pkg::depth_cfg_t cfg,
  input  wire matmul_pkg::b_tile_t    in_tile,
  input  wire                         in_valid,
  output logic                        in_ready,
  output matmul_pkg::b_tile_t         out_tile,
  output logic                        out_valid,
  input  wire                         out_ready
);

  matmul_pkg::buf_state_t           state_q;
  matmul_pkg::b_tile_t              mem [matmul_pkg::BUF_DEPTH];
  // Shared read and write index into the set
  logic [matmul_pkg::BUF_IDX_W-1:0] idx_q;
  logic [matmul_pkg::BUF_IDX_W:0]   idx_inc;
  logic [matmul_pkg::BUF_IDX_W:0]   set_size;
  // Replay passes completed
  matmul_pkg::depth_t               pass_q;
  logic                             stage_free;
  logic                             in_fire;
  logic                             replay_load;
  logic                             last_entry;
  logic                             last_pass;

  // Tiles in one B set
  assign set_size    = cfg.inner * cfg.b_cols;

  // Output stage loads when empty or draining
  assign stage_free  = !out_valid || out_ready;
  assign in_ready    = (state_q == matmul_pkg::FILL) && stage_free;
  assign in_fire     = in_valid && in_ready;
  assign replay_load = (state_q == matmul_pkg::REPLAY) && stage_free;

  assign idx_inc     = {1'b0, idx_q} + 1'b1;
  assign last_entry  = (idx_inc == set_size);
  // Replay runs a_rows-1 times
  assign last_pass   = (matmul_pkg::depth_t'(pass_q + 2'd2) == cfg.a_rows);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= matmul_pkg::FILL;
      idx_q     <= '0;
      pass_q    <= '0;
      out_valid <= 1'b0;
    end else begin
      case (state_q)
        matmul_pkg::FILL: begin
          if (in_fire) begin
            if (last_entry) begin
              idx_q  <= '0;
              pass_q <= '0;
              // Single A tile row needs no replay
              if (cfg.a_rows != 2'd1) begin
                state_q <= matmul_pkg::REPLAY;
              end
            end else begin
              idx_q <= idx_inc[matmul_pkg::BUF_IDX_W-1:0];
            end
          end
        end
        matmul_pkg::REPLAY: begin
          if (replay_load) begin
            if (last_entry) begin
              idx_q <= '0;
              if (last_pass) begin
                state_q <= matmul_pkg::FILL;
                pass_q  <= '0;
              end else begin
                pass_q <= pass_q + 2'd1;
              end
            end else begin
              idx_q <= idx_inc[matmul_pkg::BUF_IDX_W-1:0];
            end
          end
        end
        default: state_q <= matmul_pkg::FILL;
      endcase

      // Output stage valid
      if (in_fire || replay_load) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  // Store while forwarding in FILL, read back in REPLAY
  always_ff @(posedge clk) begin
    if (in_fire) begin
      mem[idx_q] <= in_tile;
      out_tile   <= in_tile;
    end else if (replay_load) begin
      out_tile <= mem[idx_q];
    end
  end

endmodule

`default_nettype wire

// ==== hw/tile_mac.sv ====
// Tile multiplier forming a registered 2x2 by 2x2 signed product in one stage
`timescale 1ns/1ps
`default_nettype none

module tile_mac (
  input  wire                      clk,
  input  wire                      rst,
  input  wire matmul_pkg::a_tile_t a_tile,
  input  wire                      a_valid,
  output logic                     a_ready,
  input  wire matmul_pkg::b_tile_t b_tile,
  input  wire                      b_valid,
  output logic                     b_ready,
  output matmul_pkg::prod_tile_t   p_tile,
  output logic                     p_valid,
  input  wire                      p_ready
);

  logic stage_free;
  logic fire;

  // Row r of A against column c of B at full precision
  function automatic matmul_pkg::prod_elem_t dot_row_col(
    input matmul_pkg::a_tile_t a,
    input matmul_pkg::b_tile_t b,
    input int                  r,
    input int                  c
  );
    matmul_pkg::prod_elem_t sum;
    matmul_pkg::prod_elem_t term;
    sum = '0;
    for (int k = 0; k < matmul_pkg::TILE_DIM; k++) begin
      // Operands sign-extend to the product width before the multiply
      term = $signed(a.e[r*matmul_pkg::TILE_DIM+k]) * $signed(b.e[k*matmul_pkg::TILE_DIM+c]);
      sum  = sum + term;
    end
    return sum;
  endfunction

  // Output register empty or draining
  assign stage_free = !p_valid || p_ready;

  // Both tiles go together
  assign a_ready    = b_valid && stage_free;
  assign b_ready    = a_valid && stage_free;
  assign fire       = a_valid && b_valid && stage_free;

  always_ff @(posedge clk) begin
    if (rst) begin
      p_valid <= 1'b0;
    end else if (fire) begin
      p_valid <= 1'b1;
    end else if (p_ready) begin
      p_valid <= 1'b0;
    end
  end

  // Product register holds its value on a stall
  always_ff @(posedge clk) begin
    if (fire) begin
      for (int r = 0; r < matmul_pkg::TILE_DIM; r++) begin
        for (int c = 0; c < matmul_pkg::TILE_DIM; c++) begin
          p_tile.e[r*matmul_pkg::TILE_DIM+c] <= dot_row_col(a_tile, b_tile, r, c);
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/tile_accumulator.sv ====
// Tile accumulator that sums depth product tiles and holds the sum until taken
`timescale 1ns/1ps
`default_nettype none

module tile_accumulator (
  input  wire                         clk,
  input  wire                         rst,
  input  wire matmul_pkg::depth_t     depth,
  input  wire matmul_pkg::prod_tile_t in_tile,
  input  wire                         in_valid,
  output logic                        in_ready,
  output matmul_pkg::acc_tile_t       out_tile,
  output logic                        out_valid,
  input  wire                         out_ready
);

  matmul_pkg::acc_state_t state_q;
  // Inputs summed so far
  matmul_pkg::depth_t     cnt_q;
  matmul_pkg::acc_tile_t  next_sum;
  logic                   in_fire;
  logic                   last_in;

  assign in_ready  = (state_q == matmul_pkg::SUM);
  assign out_valid = (state_q == matmul_pkg::HOLD);
  assign in_fire   = in_valid && in_ready;
  assign last_in   = (matmul_pkg::depth_t'(cnt_q + 2'd1) == depth);

  // First input starts a fresh sum
  always_comb begin
    for (int i = 0; i < matmul_pkg::TILE_ELEMS; i++) begin
      if (cnt_q == '0) begin
        next_sum.e[i] = $signed(in_tile.e[i]);
      end else begin
        next_sum.e[i] = out_tile.e[i] + $signed(in_tile.e[i]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= matmul_pkg::SUM;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        matmul_pkg::SUM: begin
          if (in_fire) begin
            if (last_in) begin
              state_q <= matmul_pkg::HOLD;
              cnt_q   <= '0;
            end else begin
              cnt_q <= cnt_q + 2'd1;
            end
          end
        end
        // Result stays until the consumer takes it
        matmul_pkg::HOLD: begin
          if (out_ready) begin
            state_q <= matmul_pkg::SUM;
          end
        end
        default: state_q <= matmul_pkg::SUM;
      endcase
    end
  end

  // Running sum
  always_ff @(posedge clk) begin
    if (in_fire) begin
      out_tile <= next_sum;
    end
  end

endmodule

`default_nettype wire

// ==== hw/matmul_programmable.sv ====
// Programmable tiled matrix multiplier computing C = A x B on 2x2 signed fixed-point tiles
`timescale 1ns/1ps
`default_nettype none

module matmul_programmable (
  input  wire                         clk,
  input  wire                         rst,
  input  wire matmul_pkg::depth_cfg_t cfg,
  input  wire matmul_pkg::a_tile_t    a_tile,
  input  wire                         a_valid,
  output logic                        a_ready,
  input  wire matmul_pkg::b_tile_t    b_tile,
  input  wire                         b_valid,
  output logic                        b_ready,
  output matmul_pkg::out_tile_t       c_tile,
  output logic                        c_valid,
  input  wire                         c_ready
);

  // Repeated A stream
  matmul_pkg::a_tile_t                rep_tile;
  logic                               rep_valid;
  logic                               rep_ready;
  // Buffered B stream
  matmul_pkg::b_tile_t                buf_tile;
  logic                               buf_valid;
  logic                               buf_ready;
  // Product stream
  matmul_pkg::prod_tile_t             p_tile;
  logic                               p_valid;
  logic                               p_ready;
  logic [matmul_pkg::MAX_DEPTH-1:0]   acc_in_valid;
  logic [matmul_pkg::MAX_DEPTH-1:0]   acc_in_ready;
  logic [matmul_pkg::MAX_DEPTH-1:0]   acc_out_valid;
  logic [matmul_pkg::MAX_DEPTH-1:0]   acc_out_ready;
  matmul_pkg::acc_tile_t              acc_out [matmul_pkg::MAX_DEPTH];
  matmul_pkg::acc_tile_t              sel_sum;
  // Accumulator taking the next product, and the one feeding C
  logic [matmul_pkg::ACC_PTR_W-1:0]   mat_ptr;
  logic [matmul_pkg::ACC_PTR_W-1:0]   out_ptr;

  // Step a pointer that wraps at b_cols
  function automatic logic [matmul_pkg::ACC_PTR_W-1:0] step_ptr(
    input logic [matmul_pkg::ACC_PTR_W-1:0] ptr,
    input matmul_pkg::depth_t               cols
  );
    if (matmul_pkg::depth_t'(ptr) + 2'd1 == cols) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Clamp to the 16-bit range with the fractional bits already aligned
  function automatic matmul_pkg::out_elem_t saturate(input matmul_pkg::acc_elem_t x);
    matmul_pkg::out_elem_t res;
    logic [$bits(x)-$bits(res):0] head;
    head = x[$bits(x)-1:$bits(res)-1];
    if ((&head) || !(|head)) begin
      res = x[$bits(res)-1:0];
    end else begin
      // Sign decides the limit
      res = x[$bits(x)-1] ? {1'b1, {($bits(res)-1){1'b0}}} : {1'b0, {($bits(res)-1){1'b1}}};
    end
    return res;
  endfunction

  // Each A tile once per B tile column
  a_tile_repeater u_a_rep (
    .clk      (clk),
    .rst      (rst),
    .repeat_n (cfg.b_cols),
    .in_tile  (a_tile),
    .in_valid (a_valid),
    .in_ready (a_ready),
    .out_tile (rep_tile),
    .out_valid(rep_valid),
    .out_ready(rep_ready)
  );

  // B set replayed once per extra A tile row
  b_tile_buffer u_b_buf (
    .clk      (clk),
    .rst      (rst),
    .cfg      (cfg),
    .in_tile  (b_tile),
    .in_valid (b_valid),
    .in_ready (b_ready),
    .out_tile (buf_tile),
    .out_valid(buf_valid),
    .out_ready(buf_ready)
  );

  tile_mac u_mac (
    .clk    (clk),
    .rst    (rst),
    .a_tile (rep_tile),
    .a_valid(rep_valid),
    .a_ready(rep_ready),
    .b_tile (buf_tile),
    .b_valid(buf_valid),
    .b_ready(buf_ready),
    .p_tile (p_tile),
    .p_valid(p_valid),
    .p_ready(p_ready)
  );

  // One accumulator per C tile column
  for (genvar i = 0; i < matmul_pkg::MAX_DEPTH; i++) begin : g_acc
    tile_accumulator u_acc (
      .clk      (clk),
      .rst      (rst),
      .depth    (cfg.inner),
      .in_tile  (p_tile),
      .in_valid (acc_in_valid[i]),
      .in_ready (acc_in_ready[i]),
      .out_tile (acc_out[i]),
      .out_valid(acc_out_valid[i]),
      .out_ready(acc_out_ready[i])
    );
  end

  // Steer valid and ready by the pointers
  always_comb begin
    for (int i = 0; i < matmul_pkg::MAX_DEPTH; i++) begin
      acc_in_valid[i]  = p_valid && (mat_ptr == i);
      acc_out_ready[i] = c_ready && (out_ptr == i);
    end
  end

  assign p_ready = acc_in_ready[mat_ptr];
  assign c_valid = acc_out_valid[out_ptr];
  assign sel_sum = acc_out[out_ptr];

  always_comb begin
    for (int i = 0; i < matmul_pkg::TILE_ELEMS; i++) begin
      c_tile.e[i] = saturate(sel_sum.e[i]);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mat_ptr <= '0;
      out_ptr <= '0;
    end else begin
      if (p_valid && p_ready) begin
        mat_ptr <= step_ptr(mat_ptr, cfg.b_cols);
      end
      // C tiles leave in the order the products were steered
      if (c_valid && c_ready) begin
        out_ptr <= step_ptr(out_ptr, cfg.b_cols);
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb/matmul_asserts.sv ====
// Handshake and control assertions for the tiled matrix multiplier top level
`timescale 1ns/1ps
`default_nettype none

module matmul_asserts (
  input wire                                  clk,
  input wire                                  rst,
  input wire matmul_pkg::depth_cfg_t          cfg,
  input wire matmul_pkg::a_tile_t             a_tile,
  input wire                                  a_valid,
  input wire                                  a_ready,
  input wire matmul_pkg::b_tile_t             b_tile,
  input wire                                  b_valid,
  input wire                                  b_ready,
  input wire matmul_pkg::out_tile_t           c_tile,
  input wire                                  c_valid,
  input wire                                  c_ready,
  input wire matmul_pkg::buf_state_t          buf_state,
  input wire [matmul_pkg::ACC_PTR_W-1:0]      out_ptr
);

  // Valid holds with stable data until the transfer
  a_hold: assert property (@(posedge clk) disable iff (rst)
    a_valid && !a_ready |=> a_valid && $stable(a_tile))
    else $error("a stream changed before its transfer");

  b_hold: assert property (@(posedge clk) disable iff (rst)
    b_valid && !b_ready |=> b_valid && $stable(b_tile))
    else $error("b stream changed before its transfer");

  c_hold: assert property (@(posedge clk) disable iff (rst)
    c_valid && !c_ready |=> c_valid && $stable(c_tile))
    else $error("c stream changed before its transfer");

  // Replay owns the B path
  b_blocked: assert property (@(posedge clk) disable iff (rst)
    buf_state == matmul_pkg::REPLAY |-> !b_ready)
    else $error("b_ready high during replay");

  // Output idle right after reset
  reset_idle: assert property (@(posedge clk)
    rst |=> !c_valid)
    else $error("c_valid high after reset");

  // Output pointer wraps at b_cols
  ptr_range: assert property (@(posedge clk) disable iff (rst)
    {1'b0, out_ptr} < cfg.b_cols)
    else $error("output pointer out of range");

endmodule

bind matmul_programmable matmul_asserts u_asserts (
  .clk      (clk),
  .rst      (rst),
  .cfg      (cfg),
  .a_tile   (a_tile),
  .a_valid  (a_valid),
  .a_ready  (a_ready),
  .b_tile   (b_tile),
  .b_valid  (b_valid),
  .b_ready  (b_ready),
  .c_tile   (c_tile),
  .c_valid  (c_valid),
  .c_ready  (c_ready),
  .buf_state(u_b_buf.state_q),
  .out_ptr  (out_ptr)
);

`default_nettype wire

// ==== tb/tb_matmul_programmable.sv ====
// Testbench for the tiled matrix multiplier with stimulus and expected tiles from a trace file
`timescale 1ns/1ps
`default_nettype none

module tb_matmul_programmable;

  localparam int RESET_CYCLES = 10;
  localparam int CYCLES_PER_C = 40;

  logic                   clk;
  logic                   rst;
  matmul_pkg::depth_cfg_t cfg;
  matmul_pkg::a_tile_t    a_tile;
  logic                   a_valid;
  logic                   a_ready;
  matmul_pkg::b_tile_t    b_tile;
  logic                   b_valid;
  logic                   b_ready;
  matmul_pkg::out_tile_t  c_tile;
  logic                   c_valid;
  logic                   c_ready;

  // Trace contents consumed in order
  matmul_pkg::depth_cfg_t run_cfg [$];
  matmul_pkg::a_tile_t    a_list [$];
  matmul_pkg::b_tile_t    b_list [$];
  matmul_pkg::out_tile_t  c_list [$];

  int          a_idx;
  int          b_idx;
  int          c_idx;
  int          c_target;
  int          errors;
  int          cycles = 0;
  int          cycle_limit;
  logic [15:0] lfsr;

  matmul_programmable u_matmul_programmable (
    .clk    (clk),
    .rst    (rst),
    .cfg    (cfg),
    .a_tile (a_tile),
    .a_valid(a_valid),
    .a_ready(a_ready),
    .b_tile (b_tile),
    .b_valid(b_valid),
    .b_ready(b_ready),
    .c_tile (c_tile),
    .c_valid(c_valid),
    .c_ready(c_ready)
  );

  always #10 clk = ~clk;

  // Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 16'hB400;
    end
    return n;
  endfunction

  task automatic take_bit(output logic b);
    b    = lfsr[0];
    lfsr = lfsr_step(lfsr);
  endtask

  task automatic load_trace();
    int          fd;
    int          code;
    int          ar;
    int          inn;
    int          bc;
    string       tag;
    string       rest;
    logic [31:0] w32;
    logic [63:0] w64;
    matmul_pkg::depth_cfg_t rc;
    fd = $fopen("tb/matmul_trace.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open tb/matmul_trace.txt");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", tag);
      if (code != 1) begin
        break;
      end
      if (tag == "#") begin
        // Skip the rest of a comment line
        code = $fgets(rest, fd);
      end else if (tag == "R") begin
        code = $fscanf(fd, "%d %d %d", ar, inn, bc);
        rc.a_rows = matmul_pkg::depth_t'(ar);
        rc.inner  = matmul_pkg::depth_t'(inn);
        rc.b_cols = matmul_pkg::depth_t'(bc);
        run_cfg.push_back(rc);
      end else if (tag == "A" || tag == "B") begin
        code = $fscanf(fd, "%h", w32);
        if (tag == "A") begin
          a_list.push_back(w32);
        end else begin
          b_list.push_back(w32);
        end
      end else if (tag == "C") begin
        code = $fscanf(fd, "%h", w64);
        c_list.push_back(w64);
      end else begin
        $display("ERROR: unknown record %s in trace", tag);
        errors++;
      end
    end
    $fclose(fd);
  endtask

  task automatic drive_a(input int n);
    for (int t = 0; t < n; t++) begin
      @(negedge clk);
      a_tile  = a_list[a_idx];
      a_valid = 1'b1;
      #1;
      // Ready is settled mid-cycle
      while (!a_ready) begin
        @(negedge clk);
        #1;
      end
      a_idx++;
    end
    @(negedge clk);
    a_valid = 1'b0;
  endtask

  task automatic drive_b(input int n);
    for (int t = 0; t < n; t++) begin
      @(negedge clk);
      b_tile  = b_list[b_idx];
      b_valid = 1'b1;
      #1;
      while (!b_ready) begin
        @(negedge clk);
        #1;
      end
      b_idx++;
    end
    @(negedge clk);
    b_valid = 1'b0;
  endtask

  task automatic check_c();
    matmul_pkg::out_tile_t exp;
    if (c_idx >= c_list.size()) begin
      $display("ERROR: unexpected C tile at %0t", $time);
      errors++;
      return;
    end
    exp = c_list[c_idx];
    for (int i = 0; i < matmul_pkg::TILE_ELEMS; i++) begin
      if (c_tile.e[i] !== exp.e[i]) begin
        $display("MISMATCH time=%0t signal=c_tile.e[%0d] expected=%h actual=%h",
                 $time, i, exp.e[i], c_tile.e[i]);
        errors++;
      end
    end
    c_idx++;
  endtask

  // Random c_ready stalls about one cycle in four
  initial begin : c_side
    logic s0;
    logic s1;
    forever begin
      @(negedge clk);
      take_bit(s0);
      take_bit(s1);
      c_ready = !(s0 && s1);
      #1;
      if (!rst && c_valid && c_ready) begin
        check_c();
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("ERROR: run stalled after %0d cycles, %0d of %0d C tiles seen, %0d errors",
               cycles, c_idx, c_list.size(), errors);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin
    clk      = 1'b0;
    rst      = 1'b1;
    cfg      = '{a_rows: 2'd1, inner: 2'd1, b_cols: 2'd1};
    a_tile   = '0;
    a_valid  = 1'b0;
    b_tile   = '0;
    b_valid  = 1'b0;
    c_ready  = 1'b0;
    a_idx    = 0;
    b_idx    = 0;
    c_idx    = 0;
    c_target = 0;
    errors   = 0;
    lfsr     = 16'd5594;
    load_trace();
    cycle_limit = CYCLES_PER_C * c_list.size() + RESET_CYCLES;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    foreach (run_cfg[r]) begin
      // New cfg only once the previous run has drained
      @(negedge clk);
      cfg = run_cfg[r];
      c_target += int'(cfg.a_rows) * int'(cfg.b_cols);
      fork
        drive_a(int'(cfg.a_rows) * int'(cfg.inner));
        drive_b(int'(cfg.inner) * int'(cfg.b_cols));
      join
      while (c_idx < c_target) begin
        @(negedge clk);
      end
    end
    // Idle tail catches stray C tiles
    repeat (4) @(negedge clk);
    $display("errors: %0d, C tiles checked: %0d of %0d", errors, c_idx, c_list.size());
    if (errors == 0 && c_idx == c_list.size() && c_list.size() > 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== matmul_programmable.f ====
hw/matmul_pkg.sv
hw/a_tile_repeater.sv
hw/b_tile_buffer.sv
hw/tile_mac.sv
hw/tile_accumulator.sv
hw/matmul_programmable.sv
tb/matmul_asserts.sv
tb/tb_matmul_programmable.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_matmul_programmable \
  --Mdir obj_dir -o sim_tb \
  -f matmul_programmable.f

if ! ./obj_dir/sim_tb 2>&1 | tee "$LOG"; then
  echo "Result: FAILED" | tee -a "$LOG"
fi

if grep -q "Result: FAILED" "$LOG"; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

// ==== tb/matmul_trace.txt ====
# R a_rows inner b_cols, then A tiles in (i,k) order, B tiles in (k,j), C tiles in (i,j)
# A and B words hold four 8-bit elements, C words four 16-bit elements, element 0 leftmost
# 2x2 by 2x2 with negative elements
R 1 1 1
A 010203fc
B 05fa0708
C 0013000afff3ffce
# 4x4 by 4x4
R 2 2 2
A 010203ff
A 00ff0201
A fe010004
A 0100fd02
B 02000103
B 01ff0002
B ff0100fe
B 02000103
C 000400080003fffd
C 000000000008fffe
C fffc000400070005
C 00000004fffc000e
# 2x4 by 4x4
R 1 2 2
A 010203ff
A 00ff0201
B 02000103
B 01ff0002
B ff0100fe
B 02000103
C 000400080003fffd
C 000000000008fffe
# 4x2 by 2x2
R 2 1 1
A 010203ff
A fe010004
B 02000103
C 000400060005fffd
C fffd00030004000c
# 2x4 by 4x2 at the saturation limits
R 1 2 1
A 80808080
A 80800000
B 807f807f
B 807f807f
C 7fff80007fff8100
